// File: src/spi_flash_pkg.sv
package spi_flash_pkg;

  // ########################################
  // Geometry
  // ########################################
  localparam int NUM_LANES     = 4;         // Flash devices on the bridge
  localparam int LANE_W        = 2;         // paddr bits 17:16
  localparam int ADDR_W        = 18;
  localparam int DATA_W        = 8;
  localparam int FADDR_W       = 24;        // Flash byte address
  localparam int FRAME_W       = 40;        // Opcode + address + data/dummy
  localparam int CNT_W         = 6;
  localparam int REG_SPACE_BIT = 15;        // 1 = register space

  // Register space offsets
  localparam logic [REG_SPACE_BIT-1:0] REG_STATUS = 'd0;
  localparam logic [REG_SPACE_BIT-1:0] REG_WREN   = 'd1;

  // ########################################
  // Flash commands
  // ########################################
  localparam logic [7:0] CMD_READ    = 8'h0B;  // Fast read, one dummy byte
  localparam logic [7:0] CMD_PROGRAM = 8'h02;
  localparam logic [7:0] CMD_WREN    = 8'h06;
  localparam logic [7:0] CMD_RDSR    = 8'h05;

  // Bit counts minus one for the command phase
  localparam logic [CNT_W-1:0] CMD_BITS_LONG  = 6'd39;
  localparam logic [CNT_W-1:0] CMD_BITS_SHORT = 6'd7;
  localparam logic [CNT_W-1:0] READ_BITS      = 6'd8;  // Read phase length in bits

  typedef enum logic [2:0] {
    OP_READ,
    OP_PROGRAM,
    OP_WREN,
    OP_RDSR,
    OP_BAD
  } flash_op_e;

  typedef enum logic [1:0] {
    L_IDLE,
    L_COMMAND,
    L_READING,
    L_DONE
  } lane_state_e;

endpackage

// File: src/flash_cmd_builder.sv
`timescale 1ns/10ps
module flash_cmd_builder (
  input  logic                                sck,
  input  logic                                nrst,
  input  logic                                psel_i,
  input  logic                                penable_i,
  input  logic                                pwrite_i,
  input  logic [spi_flash_pkg::ADDR_W-1:0]    paddr_i,
  input  logic [spi_flash_pkg::DATA_W-1:0]    pwdata_i,
  input  logic [spi_flash_pkg::NUM_LANES-1:0] done_i,
  output logic [spi_flash_pkg::NUM_LANES-1:0] start_o,
  output logic [spi_flash_pkg::FRAME_W-1:0]   frame_o,
  output logic [spi_flash_pkg::CNT_W-1:0]     cmd_bits_o,
  output logic [spi_flash_pkg::CNT_W-1:0]     data_bits_o,
  output logic                                bad_o
);

  spi_flash_pkg::flash_op_e                    op;
  logic                                        busy;
  logic                                        finish_q;
  logic                                        accept;
  logic [spi_flash_pkg::LANE_W-1:0]            lane;
  logic [spi_flash_pkg::REG_SPACE_BIT-1:0]     offset;
  logic [spi_flash_pkg::FADDR_W-1:0]           flash_addr;
  logic [spi_flash_pkg::FRAME_W-1:0]           frame_d;
  logic [spi_flash_pkg::CNT_W-1:0]             cmd_bits_d;
  logic [spi_flash_pkg::CNT_W-1:0]             data_bits_d;

  assign accept = psel_i & penable_i & ~busy;  // Access phase of a new transfer
  assign lane   = paddr_i[spi_flash_pkg::ADDR_W-1 -: spi_flash_pkg::LANE_W];
  assign offset = paddr_i[spi_flash_pkg::REG_SPACE_BIT-1:0];
  assign flash_addr = {{(spi_flash_pkg::FADDR_W - spi_flash_pkg::REG_SPACE_BIT){1'b0}}, offset};

  // ########################################
  // Address to command decode
  // ########################################
  always_comb begin
    if (paddr_i[spi_flash_pkg::REG_SPACE_BIT]) begin
      if (!pwrite_i && (offset == spi_flash_pkg::REG_STATUS)) begin
        op = spi_flash_pkg::OP_RDSR;
      end else if (pwrite_i && (offset == spi_flash_pkg::REG_WREN)) begin
        op = spi_flash_pkg::OP_WREN;
      end else begin
        op = spi_flash_pkg::OP_BAD;  // Unmapped offset or wrong direction
      end
    end else begin
      op = pwrite_i ? spi_flash_pkg::OP_PROGRAM : spi_flash_pkg::OP_READ;
    end
  end

  always_comb begin
    frame_d     = '0;
    cmd_bits_d  = spi_flash_pkg::CMD_BITS_SHORT;
    data_bits_d = '0;
    case (op)
      spi_flash_pkg::OP_READ: begin
        frame_d     = {spi_flash_pkg::CMD_READ, flash_addr, 8'h00};  // Dummy byte last
        cmd_bits_d  = spi_flash_pkg::CMD_BITS_LONG;
        data_bits_d = spi_flash_pkg::READ_BITS;
      end
      spi_flash_pkg::OP_PROGRAM: begin
        frame_d    = {spi_flash_pkg::CMD_PROGRAM, flash_addr, pwdata_i};
        cmd_bits_d = spi_flash_pkg::CMD_BITS_LONG;
      end
      spi_flash_pkg::OP_WREN: frame_d = {spi_flash_pkg::CMD_WREN, 32'd0};
      spi_flash_pkg::OP_RDSR: begin
        frame_d     = {spi_flash_pkg::CMD_RDSR, 32'd0};
        data_bits_d = spi_flash_pkg::READ_BITS;
      end
      default: frame_d = '0;
    endcase
  end

  // ########################################
  // Launch and busy tracking
  // ########################################
  always_ff @(posedge sck) begin
    if (!nrst) begin
      busy     <= 1'b0;
      finish_q <= 1'b0;
      start_o  <= '0;
      bad_o    <= 1'b0;
    end else begin
      finish_q <= (|done_i) | bad_o;  // Release after the pready cycle
      start_o  <= '0;
      bad_o    <= 1'b0;
      if (accept) begin
        busy <= 1'b1;
        if (op == spi_flash_pkg::OP_BAD) begin
          bad_o <= 1'b1;
        end else begin
          start_o[lane] <= 1'b1;
        end
      end else if (finish_q) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge sck) begin
    if (accept) begin
      frame_o     <= frame_d;
      cmd_bits_o  <= cmd_bits_d;
      data_bits_o <= data_bits_d;
    end
  end

endmodule

// File: src/flash_lane.sv
`timescale 1ns/10ps
module flash_lane (
  input  logic                              sck,
  input  logic                              nrst,
  input  logic                              start_i,
  input  logic [spi_flash_pkg::FRAME_W-1:0] frame_i,
  input  logic [spi_flash_pkg::CNT_W-1:0]   cmd_bits_i,
  input  logic [spi_flash_pkg::CNT_W-1:0]   data_bits_i,
  output logic                              cs_n_o,
  output logic                              mosi_o,
  input  logic                              miso_i,
  output logic                              done_o,
  output logic [7:0]                        rd_byte_o
);

  spi_flash_pkg::lane_state_e               state;
  logic [spi_flash_pkg::CNT_W-1:0]          cnt;
  logic [spi_flash_pkg::CNT_W-1:0]          cmd_bits;
  logic [spi_flash_pkg::CNT_W-1:0]          data_bits;
  logic [spi_flash_pkg::FRAME_W-1:0]        shreg;
  logic                                     load;

  assign load   = start_i && (state == spi_flash_pkg::L_IDLE);
  assign cs_n_o = !((state == spi_flash_pkg::L_COMMAND) ||
                    (state == spi_flash_pkg::L_READING));
  assign mosi_o = (state == spi_flash_pkg::L_COMMAND) & shreg[spi_flash_pkg::FRAME_W-1];
  assign done_o = (state == spi_flash_pkg::L_DONE);

  // ########################################
  // Lane FSM
  // ########################################
  always_ff @(posedge sck) begin
    if (!nrst) begin
      state <= spi_flash_pkg::L_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        spi_flash_pkg::L_COMMAND: begin
          if (cnt == cmd_bits) begin
            cnt <= '0;
            if (data_bits == '0) begin
              state <= spi_flash_pkg::L_DONE;  // No read phase
            end else begin
              state <= spi_flash_pkg::L_READING;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        spi_flash_pkg::L_READING: begin
          if (cnt == data_bits - 1'b1) begin
            cnt   <= '0;
            state <= spi_flash_pkg::L_DONE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        spi_flash_pkg::L_DONE: state <= spi_flash_pkg::L_IDLE;
        default: begin
          cnt <= '0;
          if (load) begin
            state <= spi_flash_pkg::L_COMMAND;
          end
        end
      endcase
    end
  end

  // Frame shifter and read capture
  always_ff @(posedge sck) begin
    if (load) begin
      shreg     <= frame_i;
      cmd_bits  <= cmd_bits_i;
      data_bits <= data_bits_i;
    end else if (state == spi_flash_pkg::L_COMMAND) begin
      shreg <= {shreg[spi_flash_pkg::FRAME_W-2:0], 1'b0};  // MSB first
    end
    if (state == spi_flash_pkg::L_READING) begin
      rd_byte_o <= {rd_byte_o[6:0], miso_i};
    end
  end

endmodule

// File: src/flash_resp_collect.sv
`timescale 1ns/10ps
module flash_resp_collect (
  input  logic                                  sck,
  input  logic                                  nrst,
  input  logic [spi_flash_pkg::NUM_LANES-1:0]   done_i,
  input  logic [spi_flash_pkg::NUM_LANES*8-1:0] rd_byte_i,
  input  logic                                  bad_i,
  output logic [spi_flash_pkg::DATA_W-1:0]      prdata_o,
  output logic                                  pready_o,
  output logic                                  pslverr_o
);

  logic [7:0] sel_byte;

  // Only one lane can finish per transfer
  always_comb begin
    sel_byte = '0;
    for (int i = 0; i < spi_flash_pkg::NUM_LANES; i++) begin
      if (done_i[i]) begin
        sel_byte = sel_byte | rd_byte_i[i*8 +: 8];
      end
    end
  end

  // ########################################
  // APB response
  // ########################################
  always_ff @(posedge sck) begin
    if (!nrst) begin
      pready_o  <= 1'b0;
      pslverr_o <= 1'b0;
    end else begin
      pready_o  <= (|done_i) | bad_i;  // Single-cycle completion
      pslverr_o <= bad_i;
    end
  end

  always_ff @(posedge sck) begin
    if (|done_i) begin
      prdata_o <= sel_byte;
    end else if (bad_i) begin
      prdata_o <= '0;
    end
  end

endmodule

// File: src/spi_flash_bridge.sv
`timescale 1ns/10ps
module spi_flash_bridge (
  input  logic                                sck,
  input  logic                                nrst,
  input  logic                                psel_i,
  input  logic                                penable_i,
  input  logic                                pwrite_i,
  input  logic [spi_flash_pkg::ADDR_W-1:0]    paddr_i,
  input  logic [spi_flash_pkg::DATA_W-1:0]    pwdata_i,
  output logic [spi_flash_pkg::DATA_W-1:0]    prdata_o,
  output logic                                pready_o,
  output logic                                pslverr_o,
  output logic [spi_flash_pkg::NUM_LANES-1:0] cs_n_o,
  output logic [spi_flash_pkg::NUM_LANES-1:0] mosi_o,
  input  logic [spi_flash_pkg::NUM_LANES-1:0] miso_i
);

  logic [spi_flash_pkg::NUM_LANES-1:0]   start;
  logic [spi_flash_pkg::NUM_LANES-1:0]   done;
  logic [spi_flash_pkg::NUM_LANES*8-1:0] rd_byte;
  logic [spi_flash_pkg::FRAME_W-1:0]     frame;
  logic [spi_flash_pkg::CNT_W-1:0]       cmd_bits;
  logic [spi_flash_pkg::CNT_W-1:0]       data_bits;
  logic                                  bad;

  flash_cmd_builder builder_i (
    .sck         (sck),
    .nrst        (nrst),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .done_i      (done),
    .start_o     (start),
    .frame_o     (frame),
    .cmd_bits_o  (cmd_bits),
    .data_bits_o (data_bits),
    .bad_o       (bad)
  );

  // ########################################
  // One serial lane per flash device
  // ########################################
  for (genvar g = 0; g < spi_flash_pkg::NUM_LANES; g++) begin : g_lane
    flash_lane lane_i (
      .sck         (sck),
      .nrst        (nrst),
      .start_i     (start[g]),
      .frame_i     (frame),          // Shared, start picks the lane
      .cmd_bits_i  (cmd_bits),
      .data_bits_i (data_bits),
      .cs_n_o      (cs_n_o[g]),
      .mosi_o      (mosi_o[g]),
      .miso_i      (miso_i[g]),
      .done_o      (done[g]),
      .rd_byte_o   (rd_byte[g*8 +: 8])
    );
  end

  flash_resp_collect collect_i (
    .sck       (sck),
    .nrst      (nrst),
    .done_i    (done),
    .rd_byte_i (rd_byte),
    .bad_i     (bad),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o)
  );

endmodule

// File: sim/flash_model.sv
`timescale 1ns/10ps
module flash_model (
  input  logic sck,
  input  logic cs_n_i,
  input  logic mosi_i,
  output logic miso_o
);

  logic [7:0]  mem [256] = '{default: 8'hFF};  // Erased device
  logic        wel       = 1'b0;
  logic        rd_phase  = 1'b0;
  logic [39:0] rx        = '0;
  logic [7:0]  out_byte  = '0;
  int          bit_cnt   = 0;

  // ########################################
  // Serial protocol, falling edge side
  // ########################################
  always @(negedge sck) begin
    if (!cs_n_i) begin
      if (rd_phase) begin
        miso_o   <= out_byte[7];  // MSB first
        out_byte  = {out_byte[6:0], 1'b0};
      end else begin
        rx      = {rx[38:0], mosi_i};
        bit_cnt = bit_cnt + 1;
        if (bit_cnt == 8 && rx[7:0] == spi_flash_pkg::CMD_RDSR) begin
          out_byte = {6'd0, wel, 1'b0};
          rd_phase = 1'b1;
        end else if (bit_cnt == 40 && rx[39:32] == spi_flash_pkg::CMD_READ) begin
          out_byte = mem[rx[15:8]];  // Dummy byte already shifted in
          rd_phase = 1'b1;
        end
      end
    end else if (bit_cnt != 0) begin
      // Frame closed by chip select
      if (bit_cnt == 8 && rx[7:0] == spi_flash_pkg::CMD_WREN) begin
        wel = 1'b1;
      end else if (bit_cnt == 40 && rx[39:32] == spi_flash_pkg::CMD_PROGRAM && wel) begin
        mem[rx[15:8]] = rx[7:0];
        wel           = 1'b0;
      end
      bit_cnt  = 0;
      rd_phase = 1'b0;
      miso_o  <= 1'b0;
    end
  end

endmodule

// File: sim/tb_spi_flash_bridge.sv
`timescale 1ns/10ps
module tb_spi_flash_bridge;

  logic        sck;
  logic        nrst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [17:0] paddr;
  logic [7:0]  pwdata;
  logic [7:0]  prdata;
  logic        pready;
  logic        pslverr;
  wire  [3:0]  cs_n;
  wire  [3:0]  mosi;
  wire  [3:0]  miso;

  logic [7:0]  ref_mem [1024] = '{default: 8'hFF};  // Indexed by {lane, byte address}
  logic [3:0]  ref_wel        = '0;
  int          cs_low_cycles  = 0;
  integer      seed;

  string       exp_name_q[$];
  logic [7:0]  exp_data_q[$];
  logic        exp_err_q[$];
  logic        exp_chk_q[$];
  string       cmp_name;
  logic [7:0]  cmp_data;
  logic        cmp_err;
  logic        cmp_chk;

  initial begin
    sck = 1'b0;
    forever #5 sck = ~sck;
  end

  spi_flash_bridge dut_i (
    .sck       (sck),
    .nrst      (nrst),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr),
    .cs_n_o    (cs_n),
    .mosi_o    (mosi),
    .miso_i    (miso)
  );

  for (genvar g = 0; g < spi_flash_pkg::NUM_LANES; g++) begin : g_flash
    flash_model flash_i (
      .sck    (sck),
      .cs_n_i (cs_n[g]),
      .mosi_i (mosi[g]),
      .miso_o (miso[g])
    );
  end

  // ########################################
  // Reference model and checking
  // ########################################
  function automatic logic [7:0] expect_read(input logic [1:0] lane,
                                             input spi_flash_pkg::flash_op_e op,
                                             input logic [14:0] addr);
    logic [7:0] value;
    case (op)
      spi_flash_pkg::OP_READ: value = ref_mem[{lane, addr[7:0]}];
      spi_flash_pkg::OP_RDSR: value = {6'd0, ref_wel[lane], 1'b0};  // WEL in bit 1
      default: value = 8'h00;
    endcase
    return value;
  endfunction

  task automatic apply_write(input logic [1:0] lane, input spi_flash_pkg::flash_op_e op,
                             input logic [14:0] addr, input logic [7:0] data);
    if (op == spi_flash_pkg::OP_WREN) begin
      ref_wel[lane] = 1'b1;
    end else if (op == spi_flash_pkg::OP_PROGRAM && ref_wel[lane]) begin
      ref_mem[{lane, addr[7:0]}] = data;
      ref_wel[lane]              = 1'b0;
    end
  endtask

  function automatic logic [17:0] make_addr(input logic [1:0] lane, input logic reg_space,
                                            input logic [14:0] offset);
    return {lane, reg_space, offset};
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "Run aborted");
  endtask

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
      $display("** Error %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      $display("=== FAIL ===");
      $fatal(1, "Value mismatch");
    end
  endtask

  // Every completed transfer is matched against the oldest expectation
  always @(negedge sck) begin
    if (nrst && pready) begin
      if (exp_name_q.size() == 0) begin
        abort_run("A response arrived with no transfer outstanding");
      end else begin
        cmp_name = exp_name_q.pop_front();
        cmp_data = exp_data_q.pop_front();
        cmp_err  = exp_err_q.pop_front();
        cmp_chk  = exp_chk_q.pop_front();
        check_val({cmp_name, " pslverr"}, 32'(cmp_err), 32'(pslverr));
        if (cmp_chk) begin
          check_val(cmp_name, 32'(cmp_data), 32'(prdata));
        end
      end
    end
  end

  always @(negedge sck) begin
    if (cs_n != 4'hF) begin
      cs_low_cycles <= cs_low_cycles + 1;  // Any chip select active
    end
  end

  // ########################################
  // APB master
  // ########################################
  task automatic bus_transfer(input logic write, input logic [17:0] addr,
                              input logic [7:0] wdata, input string name,
                              output logic [7:0] rdata, output logic err);
    int waited;
    waited = 0;
    @(posedge sck);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge sck);
    #1;
    penable = 1'b1;
    @(negedge sck);
    while (!pready && waited < 200) begin
      @(negedge sck);
      waited++;
    end
    if (!pready) begin
      abort_run($sformatf("Timeout: %s got no pready within 200 cycles", name));
    end else begin
      rdata = prdata;
      err   = pslverr;
      @(posedge sck);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
    end
  endtask

  task automatic apb_write(input logic [17:0] addr, input logic [7:0] wdata,
                           input string name, output logic [7:0] rdata, output logic err);
    bus_transfer(1'b1, addr, wdata, name, rdata, err);
  endtask

  task automatic apb_read(input logic [17:0] addr, input string name,
                          output logic [7:0] rdata, output logic err);
    bus_transfer(1'b0, addr, 8'h00, name, rdata, err);
  endtask

  task automatic run_op(input logic [1:0] lane, input spi_flash_pkg::flash_op_e op,
                        input logic [14:0] addr, input logic [7:0] data, input string name);
    logic [7:0] rdata;
    logic       err;
    exp_name_q.push_back(name);
    exp_data_q.push_back(expect_read(lane, op, addr));
    exp_err_q.push_back(1'b0);
    exp_chk_q.push_back(op == spi_flash_pkg::OP_READ || op == spi_flash_pkg::OP_RDSR);
    apply_write(lane, op, addr, data);
    case (op)
      spi_flash_pkg::OP_READ:    apb_read(make_addr(lane, 1'b0, addr), name, rdata, err);
      spi_flash_pkg::OP_PROGRAM: apb_write(make_addr(lane, 1'b0, addr), data, name, rdata, err);
      spi_flash_pkg::OP_WREN:    apb_write(make_addr(lane, 1'b1, 15'd1), 8'h00, name, rdata, err);
      default:                   apb_read(make_addr(lane, 1'b1, 15'd0), name, rdata, err);
    endcase
  endtask

  task automatic bad_access(input logic [1:0] lane, input logic write,
                            input logic [14:0] offset, input string name);
    logic [7:0] rdata;
    logic       err;
    int         cs_before;
    cs_before = cs_low_cycles;
    exp_name_q.push_back(name);
    exp_data_q.push_back(expect_read(lane, spi_flash_pkg::OP_BAD, offset));
    exp_err_q.push_back(1'b1);
    exp_chk_q.push_back(1'b1);
    bus_transfer(write, make_addr(lane, 1'b1, offset), 8'h3C, name, rdata, err);
    check_val({name, " cs activity"}, 32'(cs_before), 32'(cs_low_cycles));
  endtask

  // ########################################
  // Test sequence
  // ########################################
  initial begin
    logic [31:0]               r;
    logic [1:0]                lane;
    spi_flash_pkg::flash_op_e  op;
    logic [14:0]               off;
    seed    = 32'hb5845835;
    nrst    = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (16) @(posedge sck);
    #1;
    nrst = 1'b1;
    @(negedge sck);
    check_val("reset cs_n", 32'hF, 32'(cs_n));
    check_val("reset pready", 32'h0, 32'(pready));

    for (int l = 0; l < 4; l++) begin
      run_op(2'(l), spi_flash_pkg::OP_READ, 15'h0040, 8'h00, $sformatf("erased lane %0d", l));
    end

    run_op(2'd0, spi_flash_pkg::OP_PROGRAM, 15'h0010, 8'h5A, "program without wren");
    run_op(2'd0, spi_flash_pkg::OP_READ, 15'h0010, 8'h00, "read after blocked program");
    run_op(2'd0, spi_flash_pkg::OP_RDSR, 15'h0000, 8'h00, "status without wren");

    run_op(2'd1, spi_flash_pkg::OP_WREN, 15'h0000, 8'h00, "write enable");
    run_op(2'd1, spi_flash_pkg::OP_RDSR, 15'h0000, 8'h00, "status after wren");
    run_op(2'd1, spi_flash_pkg::OP_PROGRAM, 15'h0121, 8'hA5, "program with wren");
    run_op(2'd1, spi_flash_pkg::OP_READ, 15'h0121, 8'h00, "read back program");
    run_op(2'd1, spi_flash_pkg::OP_RDSR, 15'h0000, 8'h00, "status after program");

    for (int i = 0; i < 60; i++) begin
      r    = $random(seed);
      lane = r[1:0];
      case (r[3:2])
        2'd0:    op = spi_flash_pkg::OP_READ;
        2'd1:    op = spi_flash_pkg::OP_PROGRAM;
        2'd2:    op = spi_flash_pkg::OP_WREN;
        default: op = spi_flash_pkg::OP_RDSR;
      endcase
      off = {r[30:24], 5'd0, r[18:16]};  // Low byte kept in 0..7 so reads hit writes
      run_op(lane, op, off, r[15:8], $sformatf("random %0d %s lane %0d", i, op.name(), lane));
    end

    // Sweep every lane so a stray write on a neighbour shows up
    for (int l = 0; l < 4; l++) begin
      for (int a = 0; a < 8; a++) begin
        run_op(2'(l), spi_flash_pkg::OP_READ, 15'(a), 8'h00,
               $sformatf("sweep lane %0d addr %0d", l, a));
      end
    end

    for (int k = 2; k < 8; k++) begin
      bad_access(2'(k % 4), k[0], 15'(k), $sformatf("bad offset %0d", k));
    end
    bad_access(2'd3, 1'b1, 15'd0, "write to status");
    bad_access(2'd2, 1'b0, 15'd1, "read of write enable");

    if (exp_name_q.size() != 0) begin
      abort_run("Transfers finished with responses still missing");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

// File: spi_flash_bridge.f
src/spi_flash_pkg.sv
src/flash_cmd_builder.sv
src/flash_lane.sv
src/flash_resp_collect.sv
src/spi_flash_bridge.sv
sim/flash_model.sv
sim/tb_spi_flash_bridge.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the bridge testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

LOG=run.log
TOP=tb_spi_flash_bridge

verilator --binary --timing --timescale 1ns/10ps -Mdir obj_dir \
  --top-module "$TOP" -f spi_flash_bridge.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
  echo "Result: simulation passed"
  exit 0
else
  echo "Result: simulation failed"
  exit 1
fi
